/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_top -Mdir obj_dir -f tb.f

run: build
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module tb_top -f tb.f

clean:
	rm -rf obj_dir

/* source/cache_ctrl.sv */
// Direct-mapped write-through cache with line refill and uncached path on a Wishbone classic master
`timescale 1ns/1ps

module cache_ctrl import mcu_pkg::*; #(
  parameter bit read_only = 1'b0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic        fence,
  output logic        ok,
  output logic        err,
  output logic [31:0] rdata,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_dat_o,
  input  logic        wb_ack,
  input  logic        wb_err,
  input  logic [31:0] wb_dat_i
);

  cache_state_t state;
  logic [num_lines-1:0] valid;
  logic [tag_bits-1:0]  tag_mem [num_lines];
  logic [31:0]          data_mem [num_lines * line_words];
  logic [word_bits-1:0] beat;
  logic                 we_q;

  logic [index_bits-1:0] idx;
  logic [word_bits-1:0]  word;
  logic [tag_bits-1:0]   tag_in;
  logic                  uncached;
  logic                  store;
  logic                  hit;
  logic                  last_beat;
  logic                  beat_done;

  assign idx       = addr[index_lsb +: index_bits];
  assign word      = addr[2 +: word_bits];
  assign tag_in    = addr[tag_lsb +: tag_bits];
  assign uncached  = addr[uncached_bit];
  assign store     = we && !read_only;  // Folds away in the instruction cache
  assign hit       = valid[idx] && (tag_mem[idx] == tag_in) && !uncached;
  assign last_beat = (beat == word_bits'(line_words - 1));
  assign beat_done = wb_cyc && wb_ack && !wb_err;
  assign wb_we     = we_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= cs_idle;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      we_q   <= 1'b0;
      ok     <= 1'b0;
      err    <= 1'b0;
      beat   <= '0;
    end else begin
      ok  <= 1'b0;
      err <= 1'b0;
      case (state)
        cs_idle: begin
          if (req && !ok && !err) begin  // The core still holds req during the ok cycle
            state <= cs_lookup;
          end
        end
        cs_lookup: begin
          if (store || uncached) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            we_q   <= store;
            state  <= cs_single;
          end else if (hit) begin
            ok    <= 1'b1;
            state <= cs_idle;
          end else begin
            beat  <= '0;
            state <= cs_refill;
          end
        end
        cs_refill: begin
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;  // Next beat starts one idle cycle after the previous ack
            wb_stb <= 1'b1;
          end else if (wb_ack || wb_err) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            beat   <= beat + 1'b1;
            if (wb_err) begin
              err   <= 1'b1;
              state <= cs_idle;
            end else if (last_beat) begin
              state <= cs_lookup;  // Answer comes from the refilled line
            end
          end
        end
        cs_single: begin
          if (wb_ack || wb_err) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            we_q   <= 1'b0;
            ok     <= !wb_err;
            err    <= wb_err;
            state  <= cs_idle;
          end
        end
        default: state <= cs_idle;
      endcase
    end
  end

  // Valid bits are cleared while a line refills so a failed refill leaves it invalid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (fence) begin
      valid <= '0;
    end else if (state == cs_lookup && !store && !uncached && !hit) begin
      valid[idx] <= 1'b0;
    end else if (state == cs_refill && beat_done && last_beat) begin
      valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == cs_lookup) begin
      if (store || uncached) begin
        wb_adr   <= {addr[31:2], 2'b00};
        wb_dat_o <= wdata;
      end else if (hit) begin
        rdata <= data_mem[{idx, word}];
      end else begin
        tag_mem[idx] <= tag_in;
      end
    end
    if (state == cs_refill && !wb_cyc) begin
      wb_adr <= {addr[31:tag_lsb], idx, beat, 2'b00};
    end
    if (state == cs_refill && beat_done) begin
      data_mem[{idx, beat}] <= wb_dat_i;
    end
    if (state == cs_single && beat_done) begin
      rdata <= wb_dat_i;
      if (we_q && hit) begin
        data_mem[{idx, word}] <= wdata;  // Keeps a hitting line in step with memory
      end
    end
  end

endmodule

/* source/core_top.sv */
// Processor subsystem top level with the core, instruction cache and data cache
`timescale 1ns/1ps

module core_top (
  input  logic        clk,
  input  logic        arst_n,
  output logic        halted,
  output logic        fault,
  output logic        ibus_cyc,
  output logic        ibus_stb,
  output logic [31:0] ibus_adr,
  input  logic        ibus_ack,
  input  logic        ibus_err,
  input  logic [31:0] ibus_dat_i,
  output logic        dbus_cyc,
  output logic        dbus_stb,
  output logic        dbus_we,
  output logic [31:0] dbus_adr,
  output logic [31:0] dbus_dat_o,
  input  logic        dbus_ack,
  input  logic        dbus_err,
  input  logic [31:0] dbus_dat_i
);

  logic        i_req;
  logic [31:0] i_addr;
  logic        i_ok;
  logic        i_err;
  logic [31:0] i_rdata;
  logic        d_req;
  logic        d_we;
  logic [31:0] d_addr;
  logic [31:0] d_wdata;
  logic        d_ok;
  logic        d_err;
  logic [31:0] d_rdata;
  logic        fence;
  logic        ibus_we;  // Stays low, watched by the protocol checker

  tiny_core core (
    .clk(clk), .arst_n(arst_n),
    .i_req(i_req), .i_addr(i_addr), .i_ok(i_ok), .i_err(i_err), .i_rdata(i_rdata),
    .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
    .d_ok(d_ok), .d_err(d_err), .d_rdata(d_rdata),
    .fence(fence), .halted(halted), .fault(fault)
  );

  cache_ctrl #(.read_only(1'b1)) icache (
    .clk(clk), .arst_n(arst_n),
    .req(i_req), .we(1'b0), .addr(i_addr), .wdata(32'h0), .fence(fence),
    .ok(i_ok), .err(i_err), .rdata(i_rdata),
    .wb_cyc(ibus_cyc), .wb_stb(ibus_stb), .wb_we(ibus_we), .wb_adr(ibus_adr), .wb_dat_o(),
    .wb_ack(ibus_ack), .wb_err(ibus_err), .wb_dat_i(ibus_dat_i)
  );

  cache_ctrl #(.read_only(1'b0)) dcache (
    .clk(clk), .arst_n(arst_n),
    .req(d_req), .we(d_we), .addr(d_addr), .wdata(d_wdata), .fence(fence),
    .ok(d_ok), .err(d_err), .rdata(d_rdata),
    .wb_cyc(dbus_cyc), .wb_stb(dbus_stb), .wb_we(dbus_we), .wb_adr(dbus_adr),
    .wb_dat_o(dbus_dat_o), .wb_ack(dbus_ack), .wb_err(dbus_err), .wb_dat_i(dbus_dat_i)
  );

endmodule

/* source/mcu_pkg.sv */
// Opcode and state enums, instruction field positions and cache geometry
package mcu_pkg;

  typedef enum logic [3:0] {
    op_addi  = 4'h0,
    op_add   = 4'h1,
    op_ld    = 4'h2,
    op_st    = 4'h3,
    op_bne   = 4'h4,
    op_fence = 4'h5,
    op_halt  = 4'h6
  } opcode_t;

  typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_halt} core_state_t;

  typedef enum logic [1:0] {cs_idle, cs_lookup, cs_refill, cs_single} cache_state_t;

  localparam int op_msb  = 31;
  localparam int op_lsb  = 28;
  localparam int rd_msb  = 27;
  localparam int rd_lsb  = 25;
  localparam int rs_msb  = 24;
  localparam int rs_lsb  = 22;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  localparam int line_words   = 4;
  localparam int num_lines    = 16;
  localparam int uncached_bit = 31;

  localparam int word_bits  = $clog2(line_words);        // Word select inside a line
  localparam int index_bits = $clog2(num_lines);
  localparam int index_lsb  = 2 + word_bits;             // Byte offset sits below the word select
  localparam int tag_lsb    = index_lsb + index_bits;
  localparam int tag_bits   = uncached_bit - tag_lsb;    // The uncached bit is not part of the tag

endpackage

/* source/tiny_core.sv */
// Multi-cycle core with register file, decoder and fetch and load/store sequencing
`timescale 1ns/1ps

module tiny_core import mcu_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  output logic        i_req,
  output logic [31:0] i_addr,
  input  logic        i_ok,
  input  logic        i_err,
  input  logic [31:0] i_rdata,
  output logic        d_req,
  output logic        d_we,
  output logic [31:0] d_addr,
  output logic [31:0] d_wdata,
  input  logic        d_ok,
  input  logic        d_err,
  input  logic [31:0] d_rdata,
  output logic        fence,
  output logic        halted,
  output logic        fault
);

  core_state_t state;
  logic [31:0] pc;
  logic [31:0] ir;
  logic [31:0] rf [8];

  opcode_t     op;
  logic [2:0]  rd_idx;
  logic [2:0]  rs_idx;
  logic [31:0] imm;
  logic [31:0] rd_val;
  logic [31:0] rs_val;
  logic [31:0] alu;
  logic [31:0] pc_next;

  assign op     = opcode_t'(ir[op_msb:op_lsb]);
  assign rd_idx = ir[rd_msb:rd_lsb];
  assign rs_idx = ir[rs_msb:rs_lsb];
  assign imm    = {{(31 - imm_msb){ir[imm_msb]}}, ir[imm_msb:imm_lsb]};
  assign rd_val = (rd_idx == 3'd0) ? 32'h0 : rf[rd_idx];  // Register 0 is hardwired to zero
  assign rs_val = (rs_idx == 3'd0) ? 32'h0 : rf[rs_idx];
  assign alu    = (op == op_add) ? rd_val + rs_val : rs_val + imm;
  assign i_addr = pc;

  always_comb begin
    pc_next = pc + 32'd4;
    if (op == op_bne && rd_val != rs_val) begin
      pc_next = pc + {imm[29:0], 2'b00};  // Branch offset counts words
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_fetch;
      pc     <= 32'h0;
      i_req  <= 1'b0;
      d_req  <= 1'b0;
      d_we   <= 1'b0;
      fence  <= 1'b0;
      halted <= 1'b0;
      fault  <= 1'b0;
    end else begin
      fence <= 1'b0;
      case (state)
        st_fetch: begin
          if (!i_req) begin
            i_req <= 1'b1;  // First fetch after reset or after a fence
          end else if (i_err) begin
            i_req  <= 1'b0;
            fault  <= 1'b1;
            halted <= 1'b1;
            state  <= st_halt;
          end else if (i_ok) begin
            i_req <= 1'b0;
            state <= st_exec;
          end
        end
        st_exec: begin
          case (op)
            op_addi, op_add, op_bne: begin
              pc    <= pc_next;
              i_req <= 1'b1;
              state <= st_fetch;
            end
            op_ld, op_st: begin
              d_req <= 1'b1;
              d_we  <= (op == op_st);
              state <= st_mem;
            end
            op_fence: begin
              fence <= 1'b1;  // Pulsed with no request outstanding
              pc    <= pc_next;
              state <= st_fetch;
            end
            op_halt: begin
              halted <= 1'b1;
              state  <= st_halt;
            end
            default: begin
              fault  <= 1'b1;
              halted <= 1'b1;
              state  <= st_halt;
            end
          endcase
        end
        st_mem: begin
          if (d_err) begin
            d_req  <= 1'b0;
            d_we   <= 1'b0;
            fault  <= 1'b1;
            halted <= 1'b1;
            state  <= st_halt;
          end else if (d_ok) begin
            d_req <= 1'b0;
            d_we  <= 1'b0;
            pc    <= pc_next;
            i_req <= 1'b1;
            state <= st_fetch;
          end
        end
        default: state <= st_halt;  // Only a reset leaves this state
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch && i_req && i_ok) begin
      ir <= i_rdata;
    end
    if (state == st_exec && (op == op_ld || op == op_st)) begin
      d_addr  <= {alu[31:2], 2'b00};
      d_wdata <= rd_val;
    end
    if (state == st_exec && (op == op_addi || op == op_add)) begin
      rf[rd_idx] <= alu;
    end
    if (state == st_mem && d_ok && !d_we) begin
      rf[rd_idx] <= d_rdata;
    end
  end

endmodule

/* tb.f */
source/mcu_pkg.sv
source/tiny_core.sv
source/cache_ctrl.sv
source/core_top.sv
test/core_top_chk.sv
test/tb_top.sv

/* test/core_top_chk.sv */
// Bus protocol, reset state and completion assertions bound into core_top
`timescale 1ns/1ps

module core_top_chk import mcu_pkg::*; (
  input logic        clk,
  input logic        arst_n,
  input logic        halted,
  input logic        fault,
  input logic        ibus_cyc,
  input logic        ibus_stb,
  input logic        ibus_we,
  input logic [31:0] ibus_adr,
  input logic        ibus_ack,
  input logic        ibus_err,
  input logic        dbus_cyc,
  input logic        dbus_stb,
  input logic        dbus_we,
  input logic [31:0] dbus_adr,
  input logic [31:0] dbus_dat_o,
  input logic        dbus_ack,
  input logic        dbus_err,
  input core_state_t core_state
);

  int   fail_count = 0;
  logic fetch_seen;  // Set once the first instruction bus cycle has started

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_seen <= 1'b0;
    end else if (ibus_cyc) begin
      fetch_seen <= 1'b1;
    end
  end

  a_reset_idle: assert property (@(posedge clk) !arst_n |->
    !ibus_cyc && !ibus_stb && !dbus_cyc && !dbus_stb && !halted && !fault)
    else begin
      $error("Outputs active during reset");
      fail_count++;
    end
  a_first_fetch: assert property (@(posedge clk) disable iff (!arst_n) !fetch_seen |->
    !dbus_cyc && !dbus_stb && core_state == st_fetch)
    else begin
      $error("Bus active before the first fetch");
      fail_count++;
    end
  a_istb_cyc: assert property (@(posedge clk) disable iff (!arst_n) ibus_stb |-> ibus_cyc)
    else begin
      $error("ibus stb without cyc");
      fail_count++;
    end
  a_dstb_cyc: assert property (@(posedge clk) disable iff (!arst_n) dbus_stb |-> dbus_cyc)
    else begin
      $error("dbus stb without cyc");
      fail_count++;
    end
  a_ihold: assert property (@(posedge clk) disable iff (!arst_n)
    ibus_stb && !ibus_ack && !ibus_err |=> ibus_stb && $stable(ibus_adr))
    else begin
      $error("ibus master outputs changed before ack");
      fail_count++;
    end
  a_dhold: assert property (@(posedge clk) disable iff (!arst_n)
    dbus_stb && !dbus_ack && !dbus_err |=>
    dbus_stb && $stable(dbus_adr) && $stable(dbus_we) && $stable(dbus_dat_o))
    else begin
      $error("dbus master outputs changed before ack");
      fail_count++;
    end
  a_idrop: assert property (@(posedge clk) disable iff (!arst_n)
    ibus_cyc && (ibus_ack || ibus_err) |=> !ibus_cyc)
    else begin
      $error("ibus cyc held after ack");
      fail_count++;
    end
  a_ddrop: assert property (@(posedge clk) disable iff (!arst_n)
    dbus_cyc && (dbus_ack || dbus_err) |=> !dbus_cyc)
    else begin
      $error("dbus cyc held after ack");
      fail_count++;
    end
  a_iwe_low: assert property (@(posedge clk) !ibus_we)
    else begin
      $error("ibus we driven high");
      fail_count++;
    end
  a_uncached_single: assert property (@(posedge clk) disable iff (!arst_n)
    dbus_cyc && dbus_adr[31] && (dbus_ack || dbus_err) |=> !dbus_cyc ##1 !dbus_cyc)
    else begin
      $error("Uncached access used more than one beat");
      fail_count++;
    end
  a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
      $error("halted fell without reset");
      fail_count++;
    end
  a_fault_cause: assert property (@(posedge clk) disable iff (!arst_n) $rose(fault) |->
    $past(ibus_err || dbus_err, 1) || $past(ibus_err || dbus_err, 2) ||
    $past(ibus_err || dbus_err, 3))
    else begin
      $error("fault rose without a recent bus error");
      fail_count++;
    end

endmodule

bind core_top core_top_chk chk (.*, .core_state(core.state));

/* test/tb_top.sv */
// Testbench top with clock, reset, instruction and data bus memory models and result checks
`timescale 1ns/1ps

module tb_top import mcu_pkg::*; ();

  logic        clk;
  logic        arst_n;
  logic        halted;
  logic        fault;
  logic        ibus_cyc;
  logic        ibus_stb;
  logic [31:0] ibus_adr;
  logic        ibus_ack;
  logic        ibus_err;
  logic [31:0] ibus_dat_i;
  logic        dbus_cyc;
  logic        dbus_stb;
  logic        dbus_we;
  logic [31:0] dbus_adr;
  logic [31:0] dbus_dat_o;
  logic        dbus_ack;
  logic        dbus_err;
  logic [31:0] dbus_dat_i;

  logic [31:0] imem [256];
  logic [31:0] dmem [1024];
  int          errors;
  int          ibus_beats;

  core_top DUT (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] encode(input opcode_t op, input int rd, input int rs,
                                         input int imm);
    logic [31:0] w;
    w = {op, rd[2:0], rs[2:0], 6'b0, imm[15:0]};
    return w;
  endfunction

  task automatic check_word(input string name, input logic [31:0] adr,
                            input logic [31:0] expected);
    logic [31:0] actual;
    actual = dmem[adr[11:2]];
    assert (actual == expected) else begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TESTS FAILED");
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    if (ibus_cyc && ibus_ack) begin
      ibus_beats++;  // Every instruction bus beat is one word of a line refill
    end
  end

  // Instruction bus slave, one ack after 0 to 3 extra wait cycles
  initial begin
    logic [31:0] seed;
    int          wait_cnt;
    logic        busy;
    seed = 32'h0f9f_ff0a;
    busy = 1'b0;
    wait_cnt = 0;
    ibus_ack = 1'b0;
    ibus_err = 1'b0;
    ibus_dat_i = '0;
    forever begin
      @(posedge clk);
      #2;
      if (ibus_ack) begin
        ibus_ack = 1'b0;
        busy = 1'b0;
      end else if (ibus_cyc && ibus_stb) begin
        if (!busy) begin
          busy = 1'b1;
          seed = lcg_next(seed);
          wait_cnt = seed[17:16];
        end
        if (wait_cnt == 0) begin
          ibus_ack = 1'b1;
          ibus_dat_i = imem[ibus_adr[9:2]];
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // Data bus slave, errors at 0x9000_0000 and above
  initial begin
    logic [31:0] seed;
    int          wait_cnt;
    logic        busy;
    seed = lcg_next(32'h0f9f_ff0a);
    busy = 1'b0;
    wait_cnt = 0;
    dbus_ack = 1'b0;
    dbus_err = 1'b0;
    dbus_dat_i = '0;
    forever begin
      @(posedge clk);
      #2;
      if (dbus_ack || dbus_err) begin
        dbus_ack = 1'b0;
        dbus_err = 1'b0;
        busy = 1'b0;
      end else if (dbus_cyc && dbus_stb) begin
        if (!busy) begin
          busy = 1'b1;
          seed = lcg_next(seed);
          wait_cnt = seed[17:16];
        end
        if (wait_cnt != 0) begin
          wait_cnt--;
        end else if (dbus_adr >= 32'h9000_0000) begin
          dbus_err = 1'b1;
        end else begin
          dbus_ack = 1'b1;
          dbus_dat_i = dmem[dbus_adr[11:2]];
          if (dbus_we) dmem[dbus_adr[11:2]] = dbus_dat_o;
        end
      end
    end
  end

  initial begin
    int          cycles;
    logic [31:0] sum;
    errors = 0;
    ibus_beats = 0;
    arst_n = 1'b0;
    for (int i = 0; i < 256; i++) imem[i] = encode(op_halt, 0, 0, i);
    for (int i = 0; i < 1024; i++) dmem[i] = 32'h5a00_0000 ^ (i * 4);
    dmem[32'h180 >> 2] = 32'h8000_0000;           // Pointer to the uncached window
    dmem[32'h184 >> 2] = 32'h9000_0000;           // Pointer to the faulting region
    dmem[32'h200 >> 2] = 32'hc0de_5a5a;           // Seen through 0x8000_0200
    imem[0]  = encode(op_addi, 1, 0, 0);
    imem[1]  = encode(op_addi, 2, 0, 1);
    imem[2]  = encode(op_addi, 3, 0, 11);
    imem[3]  = encode(op_add, 1, 2, 0);
    imem[4]  = encode(op_addi, 2, 2, 1);
    imem[5]  = encode(op_bne, 2, 3, -2);
    imem[6]  = encode(op_st, 1, 0, 'h100);
    imem[7]  = encode(op_ld, 4, 0, 'h144);         // Brings line 0x140 into the data cache
    imem[8]  = encode(op_addi, 5, 0, 'h123);
    imem[9]  = encode(op_st, 5, 0, 'h140);
    imem[10] = encode(op_ld, 6, 0, 'h140);
    imem[11] = encode(op_addi, 6, 6, 1);
    imem[12] = encode(op_st, 6, 0, 'h104);
    imem[13] = encode(op_ld, 7, 0, 'h180);
    imem[14] = encode(op_ld, 4, 7, 'h200);
    imem[15] = encode(op_st, 4, 0, 'h108);
    imem[16] = encode(op_addi, 2, 0, 0);
    imem[17] = encode(op_addi, 3, 0, 2);
    imem[18] = encode(op_addi, 5, 0, 'h11);        // Patched after its first run
    imem[19] = encode(op_st, 5, 0, 'h10c);
    imem[20] = encode(op_fence, 0, 0, 0);
    imem[21] = encode(op_addi, 2, 2, 1);
    imem[22] = encode(op_bne, 2, 3, -4);
    imem[23] = encode(op_ld, 7, 0, 'h184);
    imem[24] = encode(op_ld, 4, 7, 0);
    imem[25] = encode(op_halt, 0, 0, 0);
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    cycles = 0;
    while (!(dbus_cyc && dbus_we && dbus_adr == 32'h10c)) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20000) fail_timeout("the first marker store");
    end
    imem[18] = encode(op_addi, 5, 0, 'h77);
    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20000) fail_timeout("the core to halt");
    end
    repeat (4) @(posedge clk);
    sum = 0;
    for (int i = 1; i <= 10; i++) sum += i;
    check_word("loop_sum", 32'h100, sum);
    check_word("load_after_store", 32'h104, 32'h123 + 1);
    check_word("uncached_load", 32'h108, 32'hc0de_5a5a);
    check_word("fence_patch", 32'h10c, 32'h77);
    // Lines 0 to 6 refill once and only the two fences make lines 5, 4 and 5 refill again
    assert (ibus_beats == 10 * line_words) else begin
      $display("Mismatch icache_refills: expected %0d, actual %0d", 10 * line_words,
               ibus_beats);
      errors++;
    end
    assert (fault && halted) else begin
      $display("Bus error did not leave the core halted with fault set");
      errors++;
    end
    errors += DUT.chk.fail_count;
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
